// File: verilog.f
src/vga_text_pkg.sv
src/video_timing_if.sv
src/video_sync_generator.sv
src/inst_disassembler.sv
src/font_rom.sv
src/text_renderer.sv
src/vga_inst_display.sv
test/tb_vga_inst_display.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module tb_vga_inst_display -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/tb_vga_inst_display.sv
`timescale 1ns/1ps

module tb_vga_inst_display;
	import vga_text_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int RUN_FRAMES = 4;
	localparam int MARGIN_CYCLES = 20000;
	localparam int CELL_PX = GLYPH_W * TEXT_SCALE;
	localparam logic [COLOR_W-1:0] FULL = '1;
	localparam logic [COLOR_W-1:0] HALF = 1 << (COLOR_W - 1);

	logic iVGA_CLK;
	logic iRST_n;
	logic [31:0] inst_word;
	logic [COLOR_W-1:0] r_data;
	logic [COLOR_W-1:0] g_data;
	logic [COLOR_W-1:0] b_data;
	logic hs;
	logic vs;

	// reference raster position, started from reset like the DUT counters.
	int ref_h;
	int ref_v;
	int ref_frame;
	// the same position two clocks later, lined up with the DUT outputs.
	int d1_h;
	int d1_v;
	int d_h;
	int d_v;
	int show_frame;
	logic fg_seen;

	logic hs_q;
	logic vs_q;
	logic hs_seen;
	logic vs_seen;
	int hs_cnt;
	int hs_low;
	int vs_cnt;
	int vs_low;

	logic [15:0] lfsr_state;

	vga_inst_display UUT
	(
		.iVGA_CLK(iVGA_CLK),
		.iRST_n(iRST_n),
		.inst_word(inst_word),
		.r_data(r_data),
		.g_data(g_data),
		.b_data(b_data),
		.hs(hs),
		.vs(vs)
	);

	initial
	begin
		iVGA_CLK = 1'b0;
		forever #(CLK_PERIOD / 2) iVGA_CLK = ~iVGA_CLK;
	end

	wire pix_fg = (r_data == FULL) && (g_data == FULL) && (b_data == FULL);
	wire pix_bg = (r_data == '0) && (g_data == '0) && (b_data == HALF);
	wire pix_dark = (r_data == '0) && (g_data == '0) && (b_data == '0);
	wire d_active = (d_h < H_ACTIVE) && (d_v < V_ACTIVE);
	wire d_in_band = (d_h >= TEXT_X0) && (d_h < TEXT_X0 + TEXT_LEN * CELL_PX) &&
		(d_v >= TEXT_Y0) && (d_v < TEXT_Y0 + CELL_PX);
	wire d_frame_end = (d_h == H_TOTAL - 1) && (d_v == V_TOTAL - 1);
	wire hs_fell = hs_q && !hs;
	wire hs_rose = !hs_q && hs;
	wire vs_fell = vs_q && !vs;
	wire vs_rose = !vs_q && vs;
	int d_col;

	assign d_col = (d_h - TEXT_X0) / CELL_PX;

	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			ref_h <= 0;
			ref_v <= 0;
			ref_frame <= 1;
		end
		else if (ref_h == H_TOTAL - 1)
		begin
			ref_h <= 0;
			if (ref_v == V_TOTAL - 1)
			begin
				ref_v <= 0;
				ref_frame <= ref_frame + 1;
			end
			else
				ref_v <= ref_v + 1;
		end
		else
			ref_h <= ref_h + 1;
	end

	// the reset value sits in the blanked area outside the sync pulses.
	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			d1_h <= H_ACTIVE;
			d1_v <= 0;
			d_h <= H_ACTIVE;
			d_v <= 0;
			show_frame <= 1;
			fg_seen <= 1'b0;
		end
		else
		begin
			d1_h <= ref_h;
			d1_v <= ref_v;
			d_h <= d1_h;
			d_v <= d1_v;
			if (d_frame_end)
			begin
				show_frame <= show_frame + 1;
				fg_seen <= 1'b0;
			end
			else if (pix_fg)
				fg_seen <= 1'b1;
		end
	end

	// pulse lengths and periods of both syncs, counted in clocks.
	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			hs_q <= 1'b1;
			vs_q <= 1'b1;
			hs_seen <= 1'b0;
			vs_seen <= 1'b0;
			hs_cnt <= 0;
			vs_cnt <= 0;
			hs_low <= 0;
			vs_low <= 0;
		end
		else
		begin
			hs_q <= hs;
			vs_q <= vs;
			hs_seen <= hs_seen || hs_fell;
			vs_seen <= vs_seen || vs_fell;
			hs_cnt <= hs_fell ? 1 : hs_cnt + 1;
			vs_cnt <= vs_fell ? 1 : vs_cnt + 1;
			hs_low <= hs ? 0 : hs_low + 1;
			vs_low <= vs ? 0 : vs_low + 1;
		end
	end

	task automatic report_failure(input string msg);
		$display("Fail at %0t ns: %s", $time, msg);
		$display("Verification failed");
		$fatal(1, "stopping at the first error");
	endtask

	a_hs_period: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
		(hs_fell && hs_seen) |-> (hs_cnt == H_TOTAL))
		else report_failure("hs falls are not one line apart");
	a_hs_width: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
		hs_rose |-> (hs_low == H_SYNC))
		else report_failure("hs low pulse has the wrong length");
	a_vs_period: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
		(vs_fell && vs_seen) |-> (vs_cnt == FRAME_CYCLES))
		else report_failure("vs falls are not one frame apart");
	a_vs_width: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
		vs_rose |-> (vs_low == V_SYNC * H_TOTAL))
		else report_failure("vs low pulse has the wrong length");
	a_dark_outside: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
		!d_active |-> pix_dark)
		else report_failure("colour is not zero outside active video");
	a_fg_or_bg: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
		d_active |-> (pix_fg || pix_bg))
		else report_failure("active pixel is neither text nor background colour");
	a_fg_in_band: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
		pix_fg |-> d_in_band)
		else report_failure("text colour outside the text band");
	a_unknown_marks: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
		(pix_fg && show_frame == 2) |-> (d_col < 3))
		else report_failure("unknown opcode shows more than three marks");
	a_blank_after_reset: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
		(d_frame_end && show_frame == 1) |-> !fg_seen)
		else report_failure("text drawn in the first frame after reset");
	a_text_visible: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
		(d_frame_end && show_frame >= 2) |-> fg_seen)
		else report_failure("no text drawn for the captured instruction");

	// Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic make_unknown(output logic [31:0] w);
		logic [31:0] rnd;
		random_bits(26, rnd);
		// primary opcode 1 is not part of the instruction set.
		w = {6'h01, rnd[25:0]};
	endtask

	task automatic make_add(output logic [31:0] w);
		mips_inst_u u;
		logic [31:0] rnd;
		random_bits(15, rnd);
		u.r.op = OP_ADD[11:6];
		u.r.rs = rnd[14:10];
		u.r.rt = rnd[9:5];
		u.r.rd = rnd[4:0];
		u.r.shamt = 5'd0;
		u.r.funct = OP_ADD[5:0];
		w = u;
	endtask

	task automatic make_addi(output logic [31:0] w);
		mips_inst_u u;
		logic [31:0] rnd;
		random_bits(26, rnd);
		u.i.op = OP_ADDI[11:6];
		u.i.rs = rnd[25:21];
		u.i.rt = rnd[20:16];
		u.i.imm = rnd[15:0];
		w = u;
	endtask

	task automatic wait_for_line(input int frame, input int line);
		while (!(ref_frame == frame && ref_v == line))
			@(negedge iVGA_CLK);
	endtask

	initial
	begin
		#(CLK_PERIOD * (RUN_FRAMES * FRAME_CYCLES + MARGIN_CYCLES));
		$display("timeout: the display did not finish four frames in time");
		$display("Verification failed");
		$fatal(1, "watchdog expired");
	end

	// each word is applied mid-frame and shows up after the next frame start.
	initial
	begin
		logic [31:0] w;
		iRST_n = 1'b0;
		inst_word = '0;
		lfsr_state = 16'd5;
		repeat (2) @(negedge iVGA_CLK);
		iRST_n = 1'b1;
		wait_for_line(1, 100);
		make_unknown(w);
		inst_word = w;
		wait_for_line(2, 100);
		make_add(w);
		inst_word = w;
		wait_for_line(3, 100);
		make_addi(w);
		inst_word = w;
		while (show_frame <= RUN_FRAMES)
			@(negedge iVGA_CLK);
		$display("Verification passed");
		$finish;
	end

endmodule

// File: src/vga_inst_display.sv
`timescale 1ns/1ps

module vga_inst_display
(
	input logic iVGA_CLK,
	input logic iRST_n,
	input logic [31:0] inst_word,
	output logic [vga_text_pkg::COLOR_W-1:0] r_data,
	output logic [vga_text_pkg::COLOR_W-1:0] g_data,
	output logic [vga_text_pkg::COLOR_W-1:0] b_data,
	output logic hs,
	output logic vs
);
	import vga_text_pkg::*;

	// character line, held for a whole frame.
	text_line_t text_line;

	video_timing_if timing_bus ();

	video_sync_generator u_sync
	(
		.iVGA_CLK(iVGA_CLK),
		.iRST_n(iRST_n),
		.timing(timing_bus.source)
	);

	// the raw word is decoded through the instruction union.
	inst_disassembler u_disasm
	(
		.iVGA_CLK(iVGA_CLK),
		.iRST_n(iRST_n),
		.inst_word(inst_word),
		.timing(timing_bus.sink),
		.text_line(text_line)
	);

	text_renderer u_render
	(
		.iVGA_CLK(iVGA_CLK),
		.iRST_n(iRST_n),
		.timing(timing_bus.sink),
		.text_line(text_line),
		.r_data(r_data),
		.g_data(g_data),
		.b_data(b_data),
		.hs(hs),
		.vs(vs)
	);

endmodule

// File: src/text_renderer.sv
`timescale 1ns/1ps

module text_renderer
(
	input logic iVGA_CLK,
	input logic iRST_n,
	video_timing_if.sink timing,
	input vga_text_pkg::text_line_t text_line,
	output logic [vga_text_pkg::COLOR_W-1:0] r_data,
	output logic [vga_text_pkg::COLOR_W-1:0] g_data,
	output logic [vga_text_pkg::COLOR_W-1:0] b_data,
	output logic hs,
	output logic vs
);
	import vga_text_pkg::*;

	logic [COORD_W-1:0] rel_x;
	logic [COORD_W-1:0] rel_y;
	logic [COORD_W-1:0] sx;
	logic [COORD_W-1:0] sy;
	logic in_band;
	logic [COL_W-1:0] col;
	logic [GLYPH_BW-1:0] bit_sel;
	logic [GLYPH_BW-1:0] row_sel;
	logic [7:0] char_code;
	logic [GLYPH_W-1:0] row_bits;
	logic [GLYPH_BW-1:0] bit_q;
	logic band_q;
	logic blank_q1;
	logic hs_q1;
	logic vs_q1;
	logic [3*COLOR_W-1:0] rgb_q;

	// band coordinates, scaled down to glyph pixels.
	always_comb
	begin
		rel_x = timing.x - COORD_W'(TEXT_X0);
		rel_y = timing.y - COORD_W'(TEXT_Y0);
		in_band = timing.blank_n &&
			(timing.x >= COORD_W'(TEXT_X0)) && (rel_x < COORD_W'(TEXT_W_PX)) &&
			(timing.y >= COORD_W'(TEXT_Y0)) && (rel_y < COORD_W'(TEXT_H_PX));
		sx = rel_x / COORD_W'(TEXT_SCALE);
		sy = rel_y / COORD_W'(TEXT_SCALE);
		col = COL_W'(sx / COORD_W'(GLYPH_W));
		bit_sel = sx[GLYPH_BW-1:0];
		row_sel = sy[GLYPH_BW-1:0];
		// outside the band col is out of range, so feed a blank glyph instead.
		char_code = in_band ? text_line[col] : 8'h20;
	end

	font_rom u_font
	(
		.iVGA_CLK(iVGA_CLK),
		.char_code(char_code),
		.glyph_row(row_sel),
		.row_bits(row_bits)
	);

	// first stage runs beside the ROM read.
	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			band_q <= 1'b0;
			blank_q1 <= 1'b0;
			hs_q1 <= 1'b1;
			vs_q1 <= 1'b1;
		end
		else
		begin
			band_q <= in_band;
			blank_q1 <= timing.blank_n;
			hs_q1 <= timing.hs;
			vs_q1 <= timing.vs;
		end
	end

	always_ff @(posedge iVGA_CLK)
	begin
		bit_q <= bit_sel;
	end

	// second stage picks the colour and registers the outputs.
	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			rgb_q <= '0;
			hs <= 1'b1;
			vs <= 1'b1;
		end
		else
		begin
			hs <= hs_q1;
			vs <= vs_q1;
			if (!blank_q1)
				rgb_q <= '0;
			else if (band_q && row_bits[GLYPH_W-1-bit_q])
				rgb_q <= FG_RGB;
			else
				rgb_q <= BG_RGB;
		end
	end

	assign {b_data, g_data, r_data} = rgb_q;

	// blank_n from the timing bus, two clocks back, lines up with the colour output.
	a_dark_when_blank: assert property (
		@(posedge iVGA_CLK) disable iff (!iRST_n)
		!$past(timing.blank_n, 2) |-> ({r_data, g_data, b_data} == '0)
	)
	else
		$error("colour output not dark during blanking");

endmodule

// File: src/font_rom.sv
`timescale 1ns/1ps

module font_rom
(
	input logic iVGA_CLK,
	input logic [7:0] char_code,
	input logic [vga_text_pkg::GLYPH_BW-1:0] glyph_row,
	output logic [vga_text_pkg::GLYPH_W-1:0] row_bits
);
	import vga_text_pkg::*;

	// top row in the high byte, leftmost pixel in the MSB of each row.
	logic [GLYPH_W*GLYPH_H-1:0] glyph;

	always_comb
	begin
		case (char_code)
			" ": glyph = 64'h0000000000000000;
			"0": glyph = 64'h3C666E7666663C00;
			"1": glyph = 64'h1838181818187E00;
			"2": glyph = 64'h3C66060C30607E00;
			"3": glyph = 64'h3C66061C06663C00;
			"4": glyph = 64'h0C1C3C6C7E0C0C00;
			"5": glyph = 64'h7E607C0606663C00;
			"6": glyph = 64'h1C30607C66663C00;
			"7": glyph = 64'h7E060C1830303000;
			"8": glyph = 64'h3C66663C66663C00;
			"9": glyph = 64'h3C66663E060C3800;
			"?": glyph = 64'h3C66060C18001800;
			"X": glyph = 64'h66663C183C666600;
			"a": glyph = 64'h00003C063E663E00;
			"b": glyph = 64'h60607C6666667C00;
			"c": glyph = 64'h00003C6060603C00;
			"d": glyph = 64'h06063E6666663E00;
			"e": glyph = 64'h00003C667E603C00;
			"f": glyph = 64'h1C307C3030303000;
			"g": glyph = 64'h00003E66663E063C;
			"h": glyph = 64'h60607C6666666600;
			"i": glyph = 64'h1800381818183C00;
			"j": glyph = 64'h0C001C0C0C0C6C38;
			"k": glyph = 64'h6060666C786C6600;
			"l": glyph = 64'h3818181818183C00;
			"m": glyph = 64'h0000667F7F6B6300;
			"n": glyph = 64'h00007C6666666600;
			"o": glyph = 64'h00003C6666663C00;
			"p": glyph = 64'h00007C66667C6060;
			"q": glyph = 64'h00003E66663E0606;
			"r": glyph = 64'h00007C6660606000;
			"s": glyph = 64'h00003E603C067C00;
			"t": glyph = 64'h30307C3030301C00;
			"u": glyph = 64'h0000666666663E00;
			"v": glyph = 64'h00006666663C1800;
			"w": glyph = 64'h0000636B7F3E3600;
			"x": glyph = 64'h0000663C183C6600;
			"y": glyph = 64'h00006666663E0C78;
			"z": glyph = 64'h00007E0C18307E00;
			default: glyph = '0;
		endcase
	end

	// one clock of read latency, like a block RAM.
	always_ff @(posedge iVGA_CLK)
	begin
		row_bits <= glyph[GLYPH_W*(GLYPH_H-1-glyph_row) +: GLYPH_W];
	end

endmodule

// File: src/inst_disassembler.sv
`timescale 1ns/1ps

module inst_disassembler
(
	input logic iVGA_CLK,
	input logic iRST_n,
	input vga_text_pkg::mips_inst_u inst_word,
	video_timing_if.sink timing,
	output vga_text_pkg::text_line_t text_line
);
	import vga_text_pkg::*;

	logic [OPCODE_W-1:0] opcode;
	text_line_t line_next;

	// two ASCII digits, tens first.
	function automatic logic [15:0] dec2(input logic [4:0] v);
		logic [7:0] d1;
		logic [7:0] d0;
		d1 = 8'h30 + 8'(v / 5'd10);
		d0 = 8'h30 + 8'(v % 5'd10);
		return {d1, d0};
	endfunction

	// five ASCII digits, the least significant one in the low byte.
	function automatic logic [39:0] dec5(input logic [15:0] v);
		logic [39:0] s;
		logic [15:0] rest;
		rest = v;
		for (int k = 0; k < 5; k++)
		begin
			s[8*k +: 8] = 8'h30 + 8'(rest % 16'd10);
			rest = rest / 16'd10;
		end
		return s;
	endfunction

	// negative values get a leading n and show their magnitude.
	function automatic logic [47:0] imm_signed(input logic [15:0] v);
		logic [15:0] mag;
		mag = v[15] ? (~v + 16'd1) : v;
		return {(v[15] ? "n" : " "), dec5(mag)};
	endfunction

	function automatic logic [47:0] imm_unsigned(input logic [15:0] v);
		return {" ", dec5(v)};
	endfunction

	function automatic logic [23:0] reg_txt(input logic [4:0] r);
		return {"X", dec2(r)};
	endfunction

	// s holds len characters right aligned; move them to the left and pad.
	function automatic text_line_t left_align(input logic [LINE_W-1:0] s, input int len);
		text_line_t line;
		for (int i = 0; i < TEXT_LEN; i++)
		begin
			if (i < len)
				line[i] = s[8*(len-1-i) +: 8];
			else
				line[i] = " ";
		end
		return line;
	endfunction

	// mnemonics are five characters wide, trailing spaces included.
	function automatic text_line_t fmt_rrr(input logic [39:0] mnem, input logic [4:0] a,
		input logic [4:0] b, input logic [4:0] c);
		return left_align(LINE_W'({mnem, reg_txt(a), " ", reg_txt(b), " ", reg_txt(c)}), 16);
	endfunction

	function automatic text_line_t fmt_shift(input logic [39:0] mnem, input logic [4:0] a,
		input logic [4:0] b, input logic [4:0] sh);
		return left_align(LINE_W'({mnem, reg_txt(a), " ", reg_txt(b), " ", dec2(sh)}), 15);
	endfunction

	function automatic text_line_t fmt_rri(input logic [39:0] mnem, input logic [4:0] a,
		input logic [4:0] b, input logic [47:0] imm);
		return left_align(LINE_W'({mnem, reg_txt(a), " ", reg_txt(b), " ", imm}), 19);
	endfunction

	// loads and stores put the base register after the offset.
	function automatic text_line_t fmt_mem(input logic [39:0] mnem, input logic [4:0] rt,
		input logic [4:0] rs, input logic [47:0] imm);
		return left_align(LINE_W'({mnem, reg_txt(rt), " ", imm, " ", reg_txt(rs)}), 19);
	endfunction

	// funct only takes part in decoding for R-type words.
	assign opcode = (inst_word.r.op == 6'd0) ? {inst_word.r.op, inst_word.r.funct} :
		{inst_word.i.op, 6'd0};

	always_comb
	begin
		case (opcode)
			OP_ADD:  line_next = fmt_rrr("add  ", inst_word.r.rd, inst_word.r.rs, inst_word.r.rt);
			OP_ADDU: line_next = fmt_rrr("addu ", inst_word.r.rd, inst_word.r.rs, inst_word.r.rt);
			OP_SUB:  line_next = fmt_rrr("sub  ", inst_word.r.rd, inst_word.r.rs, inst_word.r.rt);
			OP_SUBU: line_next = fmt_rrr("subu ", inst_word.r.rd, inst_word.r.rs, inst_word.r.rt);
			OP_AND:  line_next = fmt_rrr("and  ", inst_word.r.rd, inst_word.r.rs, inst_word.r.rt);
			OP_OR:   line_next = fmt_rrr("or   ", inst_word.r.rd, inst_word.r.rs, inst_word.r.rt);
			OP_XOR:  line_next = fmt_rrr("xor  ", inst_word.r.rd, inst_word.r.rs, inst_word.r.rt);
			OP_NOR:  line_next = fmt_rrr("nor  ", inst_word.r.rd, inst_word.r.rs, inst_word.r.rt);
			OP_SLT:  line_next = fmt_rrr("slt  ", inst_word.r.rd, inst_word.r.rs, inst_word.r.rt);
			OP_SGT:  line_next = fmt_rrr("sgt  ", inst_word.r.rd, inst_word.r.rs, inst_word.r.rt);
			OP_SLL:  line_next = fmt_shift("sll  ", inst_word.r.rd, inst_word.r.rt,
				inst_word.r.shamt);
			OP_SRL:  line_next = fmt_shift("srl  ", inst_word.r.rd, inst_word.r.rt,
				inst_word.r.shamt);
			OP_JR:   line_next = left_align(LINE_W'({"jr   ", reg_txt(inst_word.r.rs)}), 8);
			OP_ADDI: line_next = fmt_rri("addi ", inst_word.i.rt, inst_word.i.rs,
				imm_signed(inst_word.i.imm));
			OP_SLTI: line_next = fmt_rri("slti ", inst_word.i.rt, inst_word.i.rs,
				imm_signed(inst_word.i.imm));
			OP_ANDI: line_next = fmt_rri("andi ", inst_word.i.rt, inst_word.i.rs,
				imm_unsigned(inst_word.i.imm));
			OP_ORI:  line_next = fmt_rri("ori  ", inst_word.i.rt, inst_word.i.rs,
				imm_unsigned(inst_word.i.imm));
			OP_XORI: line_next = fmt_rri("xori ", inst_word.i.rt, inst_word.i.rs,
				imm_unsigned(inst_word.i.imm));
			OP_LW:   line_next = fmt_mem("lw   ", inst_word.i.rt, inst_word.i.rs,
				imm_signed(inst_word.i.imm));
			OP_SW:   line_next = fmt_mem("sw   ", inst_word.i.rt, inst_word.i.rs,
				imm_signed(inst_word.i.imm));
			// branches list the compared registers in source order.
			OP_BEQ:  line_next = fmt_rri("beq  ", inst_word.i.rs, inst_word.i.rt,
				imm_signed(inst_word.i.imm));
			OP_BNE:  line_next = fmt_rri("bne  ", inst_word.i.rs, inst_word.i.rt,
				imm_signed(inst_word.i.imm));
			OP_J:    line_next = left_align(LINE_W'({"j    ", "addrr"}), 10);
			OP_JAL:  line_next = left_align(LINE_W'({"jal  ", "addrr"}), 10);
			OP_HLT:  line_next = left_align(LINE_W'("hlt"), 3);
			default: line_next = left_align(LINE_W'("???"), 3);
		endcase
	end

	// the line is only replaced between frames, so a frame never tears.
	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
			text_line <= BLANK_LINE;
		else if (timing.frame_start)
			text_line <= line_next;
	end

endmodule

// File: src/video_sync_generator.sv
`timescale 1ns/1ps

module video_sync_generator
(
	input logic iVGA_CLK,
	input logic iRST_n,
	video_timing_if.source timing
);
	import vga_text_pkg::*;

	logic [COORD_W-1:0] h_cnt;
	logic [COORD_W-1:0] v_cnt;
	logic h_last;
	logic v_last;
	logic h_sync_on;
	logic v_sync_on;

	assign h_last = (h_cnt == COORD_W'(H_TOTAL - 1));
	assign v_last = (v_cnt == COORD_W'(V_TOTAL - 1));

	// pixel counter runs every clock, line counter steps at the end of each line.
	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			h_cnt <= '0;
			v_cnt <= '0;
		end
		else if (h_last)
		begin
			h_cnt <= '0;
			if (v_last)
				v_cnt <= '0;
			else
				v_cnt <= v_cnt + 1'b1;
		end
		else
		begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// the strobe is registered from the last pixel of the frame, so it lands on
	// the clock where both counters are back at zero.
	// the frame that begins right out of reset therefore has no strobe.
	always_ff @(posedge iVGA_CLK or negedge iRST_n)
	begin
		if (!iRST_n)
			timing.frame_start <= 1'b0;
		else
			timing.frame_start <= h_last && v_last;
	end

	assign h_sync_on = (h_cnt >= COORD_W'(H_ACTIVE + H_FRONT)) &&
		(h_cnt < COORD_W'(H_ACTIVE + H_FRONT + H_SYNC));
	assign v_sync_on = (v_cnt >= COORD_W'(V_ACTIVE + V_FRONT)) &&
		(v_cnt < COORD_W'(V_ACTIVE + V_FRONT + V_SYNC));

	assign timing.hs = !h_sync_on;
	assign timing.vs = !v_sync_on;
	assign timing.blank_n = (h_cnt < COORD_W'(H_ACTIVE)) && (v_cnt < COORD_W'(V_ACTIVE));

	assign timing.x = h_cnt;
	assign timing.y = v_cnt;

	// the renderer indexes by x, so it must never leave the line.
	a_x_in_line: assert property (
		@(posedge iVGA_CLK) disable iff (!iRST_n)
		timing.x < COORD_W'(H_TOTAL)
	)
	else
		$error("pixel counter ran past the end of the line");

	// a frame must never begin inside the vertical sync pulse.
	a_frame_outside_vsync: assert property (
		@(posedge iVGA_CLK) disable iff (!iRST_n)
		timing.frame_start |-> timing.vs
	)
	else
		$error("frame start seen during vertical sync");

endmodule

// File: src/video_timing_if.sv
`timescale 1ns/1ps

interface video_timing_if;
	import vga_text_pkg::*;

	// sync pulses are active low.
	logic hs;
	logic vs;
	logic blank_n;

	// pixel position, meaningful only while blank_n is high.
	logic [COORD_W-1:0] x;
	logic [COORD_W-1:0] y;

	// high for the first clock of each frame.
	logic frame_start;

	modport source
	(
		output hs, vs, blank_n, x, y, frame_start
	);

	modport sink
	(
		input hs, vs, blank_n, x, y, frame_start
	);

endinterface

// File: src/vga_text_pkg.sv
package vga_text_pkg;

	// 640x480 at 60 Hz, all horizontal values in pixel clocks.
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT  = 16;
	localparam int H_SYNC   = 96;
	localparam int H_BACK   = 48;
	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	// vertical values are in lines.
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT  = 10;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 33;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	localparam int COORD_W = 10;
	localparam int COLOR_W = 4;

	// the text band is centred on the screen.
	localparam int TEXT_LEN   = 24;
	localparam int TEXT_SCALE = 2;
	localparam int GLYPH_W    = 8;
	localparam int GLYPH_H    = 8;
	localparam int GLYPH_BW   = $clog2(GLYPH_W);
	localparam int COL_W      = $clog2(TEXT_LEN);
	localparam int TEXT_W_PX  = TEXT_LEN * GLYPH_W * TEXT_SCALE;
	localparam int TEXT_H_PX  = GLYPH_H * TEXT_SCALE;
	localparam int TEXT_X0    = (H_ACTIVE - TEXT_W_PX) / 2;
	localparam int TEXT_Y0    = (V_ACTIVE - TEXT_H_PX) / 2;
	localparam int LINE_W     = 8 * TEXT_LEN;

	// colours are packed as {b, g, r}.
	localparam logic [3*COLOR_W-1:0] FG_RGB = '1;
	localparam logic [3*COLOR_W-1:0] BG_RGB = {1'b1, {(3*COLOR_W-1){1'b0}}};

	// index 0 is the leftmost character on screen.
	typedef logic [0:TEXT_LEN-1][7:0] text_line_t;

	localparam text_line_t BLANK_LINE = {TEXT_LEN{8'h20}};

	// combined opcode is the primary opcode followed by funct.
	localparam int OPCODE_W = 12;
	localparam logic [OPCODE_W-1:0] OP_ADD  = {6'h00, 6'h20};
	localparam logic [OPCODE_W-1:0] OP_ADDU = {6'h00, 6'h21};
	localparam logic [OPCODE_W-1:0] OP_SUB  = {6'h00, 6'h22};
	localparam logic [OPCODE_W-1:0] OP_SUBU = {6'h00, 6'h23};
	localparam logic [OPCODE_W-1:0] OP_AND  = {6'h00, 6'h24};
	localparam logic [OPCODE_W-1:0] OP_OR   = {6'h00, 6'h25};
	localparam logic [OPCODE_W-1:0] OP_XOR  = {6'h00, 6'h26};
	localparam logic [OPCODE_W-1:0] OP_NOR  = {6'h00, 6'h27};
	localparam logic [OPCODE_W-1:0] OP_SLL  = {6'h00, 6'h00};
	localparam logic [OPCODE_W-1:0] OP_SRL  = {6'h00, 6'h02};
	localparam logic [OPCODE_W-1:0] OP_SLT  = {6'h00, 6'h2A};
	localparam logic [OPCODE_W-1:0] OP_SGT  = {6'h00, 6'h2B};
	localparam logic [OPCODE_W-1:0] OP_JR   = {6'h00, 6'h08};
	localparam logic [OPCODE_W-1:0] OP_ADDI = {6'h08, 6'h00};
	localparam logic [OPCODE_W-1:0] OP_ANDI = {6'h0C, 6'h00};
	localparam logic [OPCODE_W-1:0] OP_ORI  = {6'h0D, 6'h00};
	localparam logic [OPCODE_W-1:0] OP_XORI = {6'h0E, 6'h00};
	localparam logic [OPCODE_W-1:0] OP_LW   = {6'h23, 6'h00};
	localparam logic [OPCODE_W-1:0] OP_SW   = {6'h2B, 6'h00};
	localparam logic [OPCODE_W-1:0] OP_SLTI = {6'h0A, 6'h00};
	localparam logic [OPCODE_W-1:0] OP_BEQ  = {6'h04, 6'h00};
	localparam logic [OPCODE_W-1:0] OP_BNE  = {6'h05, 6'h00};
	localparam logic [OPCODE_W-1:0] OP_J    = {6'h02, 6'h00};
	localparam logic [OPCODE_W-1:0] OP_JAL  = {6'h03, 6'h00};
	localparam logic [OPCODE_W-1:0] OP_HLT  = {6'h3F, 6'h00};

	// one instruction word seen as R-type or as I-type.
	// the low 26 bits of the I view also hold the jump target.
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0]  op;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i;
	} mips_inst_u;

endpackage
